/* list.f */
+incdir+rtl
rtl/remap_map_pkg.sv
rtl/bridge_txn_pkg.sv
rtl/remap_window_table.sv
rtl/addr_remap_pipe.sv
rtl/pipe_slice.sv
rtl/addr_remap_bridge.sv
sim/tb_addr_remap_bridge.sv

/* rtl/addr_remap_bridge.sv */
// Address remapping bridge top with window table, remap pipeline and port slices
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module addr_remap_bridge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    up_valid,
    output logic                    up_ready,
    input  bridge_txn_pkg::addr_t   up_addr,
    input  logic                    up_we,
    input  bridge_txn_pkg::data_t   up_wdata,
    input  bridge_txn_pkg::strb_t   up_strb,
    output logic                    dn_valid,
    input  logic                    dn_ready,
    output bridge_txn_pkg::addr_t   dn_addr,
    output logic                    dn_we,
    output bridge_txn_pkg::data_t   dn_wdata,
    output bridge_txn_pkg::strb_t   dn_strb,
    input  logic                    dn_rsp_valid,
    output logic                    dn_rsp_ready,
    input  bridge_txn_pkg::data_t   dn_rsp_rdata,
    input  logic                    dn_rsp_err,
    output logic                    up_rsp_valid,
    input  logic                    up_rsp_ready,
    output bridge_txn_pkg::data_t   up_rsp_rdata,
    output logic                    up_rsp_err,
    input  logic                    cfg_we,
    input  remap_map_pkg::win_idx_t cfg_idx,
    input  bridge_txn_pkg::addr_t   cfg_base,
    input  bridge_txn_pkg::addr_t   cfg_limit,
    input  bridge_txn_pkg::addr_t   cfg_target,
    input  logic                    cfg_en,
    output logic                    fault_valid,
    output bridge_txn_pkg::addr_t   fault_addr,
    output logic [7:0]              fault_count,
    input  logic                    fault_clr
);
    import bridge_txn_pkg::*;
    import remap_map_pkg::*;

    window_t     windows [`BRIDGE_NUM_WINDOWS];
    bridge_req_t up_req;
    bridge_req_t pipe_req;
    bridge_req_t dn_req;
    bridge_rsp_t dn_rsp;
    bridge_rsp_t up_rsp;
    logic        pipe_valid;
    logic        pipe_ready;

    assign up_req   = '{addr: up_addr, we: up_we, wdata: up_wdata, strb: up_strb};
    assign dn_addr  = dn_req.addr;
    assign dn_we    = dn_req.we;
    assign dn_wdata = dn_req.wdata;
    assign dn_strb  = dn_req.strb;

    assign dn_rsp       = '{rdata: dn_rsp_rdata, err: dn_rsp_err};
    assign up_rsp_rdata = up_rsp.rdata;
    assign up_rsp_err   = up_rsp.err;

    remap_window_table remap_window_table_i (
        .clk, .rst_n, .cfg_we, .cfg_idx, .cfg_base, .cfg_limit, .cfg_target, .cfg_en,
        .windows
    );

    addr_remap_pipe addr_remap_pipe_i (
        .clk, .rst_n,
        .in_valid (up_valid), .in_ready (up_ready), .in_req (up_req),
        .windows,
        .out_valid (pipe_valid), .out_ready (pipe_ready), .out_req (pipe_req),
        .fault_clr, .fault_valid, .fault_addr, .fault_count
    );

    // Request side toward the slave
    pipe_slice #(.payload_t(bridge_req_t)) req_slice (
        .clk, .rst_n,
        .in_valid (pipe_valid), .in_ready (pipe_ready), .in_data (pipe_req),
        .out_valid (dn_valid), .out_ready (dn_ready), .out_data (dn_req)
    );

    // Responses pass back unchanged
    pipe_slice #(.payload_t(bridge_rsp_t)) rsp_slice (
        .clk, .rst_n,
        .in_valid (dn_rsp_valid), .in_ready (dn_rsp_ready), .in_data (dn_rsp),
        .out_valid (up_rsp_valid), .out_ready (up_rsp_ready), .out_data (up_rsp)
    );

endmodule

`default_nettype wire

/* rtl/addr_remap_pipe.sv */
// Two-stage window match and address translation pipeline with fault capture
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module addr_remap_pipe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  bridge_txn_pkg::bridge_req_t  in_req,
    input  remap_map_pkg::window_t       windows [`BRIDGE_NUM_WINDOWS],
    output logic                         out_valid,
    input  logic                         out_ready,
    output bridge_txn_pkg::bridge_req_t  out_req,
    input  logic                         fault_clr,
    output logic                         fault_valid,
    output bridge_txn_pkg::addr_t        fault_addr,
    output logic [7:0]                   fault_count
);
    import bridge_txn_pkg::*;
    import remap_map_pkg::*;

    // Combinational match of the incoming address
    logic        m_hit;
    win_idx_t    m_idx;
    addr_t       m_offset;

    logic        s1_valid;
    bridge_req_t s1_req;
    addr_t       s1_offset;
    win_idx_t    s1_idx;
    logic        s1_hit;

    logic        s2_valid;
    bridge_req_t s2_req;
    logic        s2_hit;

    logic        s2_free;
    logic        s1_move;
    logic        miss_in;

    // Scan downwards so the lowest matching index is left standing
    always_comb begin
        m_hit    = 1'b0;
        m_idx    = '0;
        m_offset = '0;
        for (int i = `BRIDGE_NUM_WINDOWS - 1; i >= 0; i--) begin
            if (windows[i].en && in_req.addr >= windows[i].base &&
                in_req.addr <= windows[i].limit) begin
                m_hit    = 1'b1;
                m_idx    = win_idx_t'(i);
                m_offset = in_req.addr - windows[i].base;
            end
        end
    end

    // A miss in stage 2 retires on its own, a hit waits for out_ready
    assign s2_free  = !s2_valid || !s2_hit || out_ready;
    assign s1_move  = s1_valid && s2_free;
    assign in_ready = !s1_valid || s2_free;
    assign miss_in  = s1_move && !s1_hit;

    assign out_valid = s2_valid && s2_hit;
    assign out_req   = s2_req;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (in_ready) s1_valid <= in_valid;
            if (s2_free)  s2_valid <= s1_valid;
        end
    end

    // Stage 1 keeps the offset from the window base
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_req    <= in_req;
            s1_offset <= m_offset;
            s1_idx    <= m_idx;
            s1_hit    <= m_hit;
        end
    end

    // Stage 2 adds the target of the window picked in stage 1
    always_ff @(posedge clk) begin
        if (s1_move) begin
            s2_req      <= s1_req;
            s2_req.addr <= s1_offset + windows[s1_idx].target;
            s2_hit      <= s1_hit;
        end
    end

    // Sticky fault, clear wins over a new miss
    always_ff @(posedge clk) begin
        if (rst_n) begin
            fault_valid <= 1'b0;
            fault_count <= 8'd0;
        end else if (fault_clr) begin
            fault_valid <= 1'b0;
            fault_count <= 8'd0;
        end else if (miss_in) begin
            fault_valid <= 1'b1;
            if (fault_count != 8'hFF) fault_count <= fault_count + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_in && !fault_valid) fault_addr <= s1_req.addr;
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_req)
    );

    // An item headed for forwarding really lies inside its enabled window
    a_forward_hits: assert property (
        @(posedge clk) disable iff (rst_n)
        s1_move && s1_hit |->
            windows[s1_idx].en &&
            s1_offset <= windows[s1_idx].limit - windows[s1_idx].base
    );

endmodule

`default_nettype wire

/* rtl/bridge_defines.svh */
// Bridge width and window count macros
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Request address width in bits
`define BRIDGE_ADDR_W 32

// Read and write data width in bits
`define BRIDGE_DATA_W 32

// Number of software programmable remap windows
`define BRIDGE_NUM_WINDOWS 4

`endif

/* rtl/bridge_txn_pkg.sv */
// Address, data, request and response types of the bridge ports
`default_nettype none

`include "bridge_defines.svh"

package bridge_txn_pkg;

    typedef logic [`BRIDGE_ADDR_W-1:0]   addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0]   data_t;
    typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;

    // Single beat request, strobes only matter for writes
    typedef struct packed {
        addr_t addr;
        logic  we;
        data_t wdata;
        strb_t strb;
    } bridge_req_t;

    // Response returned by the slave side
    typedef struct packed {
        data_t rdata;
        logic  err;
    } bridge_rsp_t;

endpackage

`default_nettype wire

/* rtl/pipe_slice.sv */
// Full-throughput valid/ready register slice with a skid entry
`timescale 1ns/1ns
`default_nettype none

module pipe_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     main_valid;
    payload_t main_data;
    logic     skid_valid;
    payload_t skid_data;

    logic     in_fire;
    logic     main_free;

    // Ready comes straight from a flop
    assign in_ready  = !skid_valid;
    assign in_fire   = in_valid && in_ready;
    assign main_free = !main_valid || out_ready;

    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // Skid drains first, input is blocked meanwhile
            main_valid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_free && in_fire) begin
            skid_data <= in_data;
        end
    end

    // With the skid entry full an offered item has to wait upstream unchanged
    a_skid_hold: assert property (
        @(posedge clk) disable iff (rst_n)
        in_valid && skid_valid |=> in_valid && $stable(in_data)
    );

endmodule

`default_nettype wire

/* rtl/remap_map_pkg.sv */
// Remap window entry type and window index type
`default_nettype none

`include "bridge_defines.svh"

package remap_map_pkg;

    // Selects one entry of the window table
    typedef logic [$clog2(`BRIDGE_NUM_WINDOWS)-1:0] win_idx_t;

    // One remap window, base and limit are both inclusive
    typedef struct packed {
        logic                      en;
        logic [`BRIDGE_ADDR_W-1:0] base;
        logic [`BRIDGE_ADDR_W-1:0] limit;
        // Downstream address that base maps onto
        logic [`BRIDGE_ADDR_W-1:0] target;
    } window_t;

endpackage

`default_nettype wire

/* rtl/remap_window_table.sv */
// Register table of remap windows written through the configuration strobe
`timescale 1ns/1ns
`default_nettype none

`include "bridge_defines.svh"

module remap_window_table (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_we,
    input  remap_map_pkg::win_idx_t  cfg_idx,
    input  bridge_txn_pkg::addr_t    cfg_base,
    input  bridge_txn_pkg::addr_t    cfg_limit,
    input  bridge_txn_pkg::addr_t    cfg_target,
    input  logic                     cfg_en,
    output remap_map_pkg::window_t   windows [`BRIDGE_NUM_WINDOWS]
);
    import bridge_txn_pkg::*;

    logic  en_q     [`BRIDGE_NUM_WINDOWS];
    addr_t base_q   [`BRIDGE_NUM_WINDOWS];
    addr_t limit_q  [`BRIDGE_NUM_WINDOWS];
    addr_t target_q [`BRIDGE_NUM_WINDOWS];

    // Enables come up cleared so nothing is forwarded before setup
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `BRIDGE_NUM_WINDOWS; i++) begin
                en_q[i] <= 1'b0;
            end
        end else if (cfg_we) begin
            en_q[cfg_idx] <= cfg_en;
        end
    end

    // Address fields of the addressed entry
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            base_q[cfg_idx]   <= cfg_base;
            limit_q[cfg_idx]  <= cfg_limit;
            target_q[cfg_idx] <= cfg_target;
        end
    end

    always_comb begin
        for (int i = 0; i < `BRIDGE_NUM_WINDOWS; i++) begin
            windows[i].en     = en_q[i];
            windows[i].base   = base_q[i];
            windows[i].limit  = limit_q[i];
            windows[i].target = target_q[i];
        end
    end

    // An enabled window that was just written must cover a real range
    a_enabled_range: assert property (
        @(posedge clk) disable iff (rst_n)
        cfg_we && cfg_en |=>
            windows[$past(cfg_idx)].limit >= windows[$past(cfg_idx)].base
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_addr_remap_bridge -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_addr_remap_bridge)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

/* sim/tb_addr_remap_bridge.sv */
// Directed testbench for the address remapping bridge with downstream and response models
`timescale 1ns/1ns
`default_nettype none

module tb_addr_remap_bridge;
    import bridge_txn_pkg::*;
    import remap_map_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int WAIT_LIMIT  = 200;
    // Accept edge to the first edge that samples dn_valid high
    localparam int REQ_LATENCY = 3;

    logic clk = 1'b0;
    logic rst_n;
    logic up_valid, up_ready, up_we;
    addr_t up_addr;
    data_t up_wdata;
    logic [3:0] up_strb;
    logic dn_valid, dn_ready, dn_we;
    addr_t dn_addr;
    data_t dn_wdata;
    logic [3:0] dn_strb;
    logic dn_rsp_valid, dn_rsp_ready, dn_rsp_err;
    data_t dn_rsp_rdata;
    logic up_rsp_valid, up_rsp_ready, up_rsp_err;
    data_t up_rsp_rdata;
    logic cfg_we, cfg_en;
    win_idx_t cfg_idx;
    addr_t cfg_base, cfg_limit, cfg_target;
    logic fault_valid, fault_clr;
    addr_t fault_addr;
    logic [7:0] fault_count;

    integer seed = 81;
    logic rand_ready = 1'b0;

    // Reference copy of the programmed window table
    logic  w_en [4];
    addr_t w_base [4];
    addr_t w_limit [4];
    addr_t w_target [4];

    logic [68:0] req_exp_q[$];
    logic [68:0] req_rx_q[$];
    logic [32:0] rsp_exp_q[$];
    logic [32:0] rsp_rx_q[$];

    addr_remap_bridge addr_remap_bridge_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both monitors sample between edges where the handshake is stable
    always @(negedge clk) begin
        if (dn_valid && dn_ready) req_rx_q.push_back({dn_addr, dn_we, dn_wdata, dn_strb});
        if (up_rsp_valid && up_rsp_ready) rsp_rx_q.push_back({up_rsp_rdata, up_rsp_err});
    end

    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            dn_ready     = $random(seed);
            up_rsp_ready = $random(seed);
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Lowest enabled window holding the address wins
    function automatic logic remap_addr(input addr_t a, output addr_t exp);
        exp = '0;
        for (int i = 0; i < 4; i++) begin
            if (w_en[i] && a >= w_base[i] && a <= w_limit[i]) begin
                exp = a - w_base[i] + w_target[i];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic program_window(input int idx, input addr_t b, input addr_t l,
                                  input addr_t t, input logic en);
        cfg_we     = 1'b1;
        cfg_idx    = win_idx_t'(idx);
        cfg_base   = b;
        cfg_limit  = l;
        cfg_target = t;
        cfg_en     = en;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
        w_en[idx]     = en;
        w_base[idx]   = b;
        w_limit[idx]  = l;
        w_target[idx] = t;
    endtask

    // Drives one request, queues the expected output for hits
    task automatic send_req(input addr_t a, input logic we, input data_t wd,
                            input logic [3:0] st);
        int n;
        addr_t exp;
        n = 0;
        if (remap_addr(a, exp)) req_exp_q.push_back({exp, we, wd, st});
        up_valid = 1'b1;
        up_addr  = a;
        up_we    = we;
        up_wdata = wd;
        up_strb  = st;
        @(negedge clk);
        while (!up_ready) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout: up_ready never rose for a request");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        up_valid = 1'b0;
    endtask

    task automatic send_rsp(input data_t rd, input logic err);
        int n;
        n = 0;
        rsp_exp_q.push_back({rd, err});
        dn_rsp_valid = 1'b1;
        dn_rsp_rdata = rd;
        dn_rsp_err   = err;
        @(negedge clk);
        while (!dn_rsp_ready) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout: dn_rsp_ready never rose for a response");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        dn_rsp_valid = 1'b0;
    endtask

    // Waits for every expected request, then compares in order
    task automatic drain_requests();
        int n;
        logic [68:0] got;
        logic [68:0] exp;
        n = 0;
        while (req_rx_q.size() < req_exp_q.size()) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout: forwarded requests missing downstream");
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_eq("forwarded request count", req_rx_q.size(), req_exp_q.size());
        while (req_exp_q.size() > 0) begin
            got = req_rx_q.pop_front();
            exp = req_exp_q.pop_front();
            check_eq("dn_addr", got[68:37], exp[68:37]);
            check_eq("dn_we", got[36], exp[36]);
            check_eq("dn_wdata", got[35:4], exp[35:4]);
            check_eq("dn_strb", got[3:0], exp[3:0]);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drain_responses();
        int n;
        logic [32:0] got;
        logic [32:0] exp;
        n = 0;
        while (rsp_rx_q.size() < rsp_exp_q.size()) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout: responses missing upstream");
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_eq("forwarded response count", rsp_rx_q.size(), rsp_exp_q.size());
        while (rsp_exp_q.size() > 0) begin
            got = rsp_rx_q.pop_front();
            exp = rsp_exp_q.pop_front();
            check_eq("up_rsp_rdata", got[32:1], exp[32:1]);
            check_eq("up_rsp_err", got[0], exp[0]);
        end
    endtask

    task automatic clear_fault();
        fault_clr = 1'b1;
        @(posedge clk);
        #1;
        fault_clr = 1'b0;
        @(negedge clk);
        check_eq("fault_valid", fault_valid, 0);
        check_eq("fault_count", fault_count, 0);
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        int n;
        check_eq("dn_valid", dn_valid, 0);
        check_eq("up_rsp_valid", up_rsp_valid, 0);
        check_eq("fault_valid", fault_valid, 0);
        check_eq("fault_count", fault_count, 0);
        check_eq("up_ready", up_ready, 1);
        check_eq("dn_rsp_ready", dn_rsp_ready, 1);
        @(posedge clk);
        #1;
        send_req(32'h0000_0100, 1'b0, 32'h0, 4'h0);
        n = 0;
        while (!fault_valid) begin
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout: unmapped request raised no fault");
            @(negedge clk);
        end
        check_eq("fault_addr", fault_addr, 32'h0000_0100);
        drain_requests();
        clear_fault();
    endtask

    task automatic test_translation();
        addr_t addrs [9] = '{32'h1000, 32'h1FFF, 32'h1800, 32'h1234, 32'h2000,
                             32'h27FF, 32'h4000, 32'h4FFF, 32'h4800};
        // Window 2 overlaps the top half of window 0
        program_window(0, 32'h1000, 32'h1FFF, 32'h8000_0000, 1'b1);
        program_window(1, 32'h4000, 32'h4FFF, 32'hA000_0000, 1'b1);
        program_window(2, 32'h1800, 32'h27FF, 32'h9000_0000, 1'b1);
        foreach (addrs[i]) begin
            send_req(addrs[i], i[0], $random(seed), 4'(i + 3));
        end
        drain_requests();
    endtask

    task automatic test_latency();
        int k;
        send_req(32'h4010, 1'b1, 32'hCAFE_0001, 4'hF);
        k = 1;
        @(negedge clk);
        while (!dn_valid) begin
            k++;
            if (k > WAIT_LIMIT) fail_now("Timeout: single request never reached dn_valid");
            @(negedge clk);
        end
        check_eq("request latency in edges", k, REQ_LATENCY);
        drain_requests();
    endtask

    task automatic test_faults();
        send_req(32'h1100, 1'b1, 32'h11, 4'h1);
        send_req(32'h3000, 1'b0, 32'h22, 4'h2);
        send_req(32'h2100, 1'b1, 32'h33, 4'h3);
        send_req(32'h5000, 1'b0, 32'h44, 4'h4);
        send_req(32'h4100, 1'b1, 32'h55, 4'h5);
        drain_requests();
        check_eq("fault_valid", fault_valid, 1);
        check_eq("fault_addr", fault_addr, 32'h3000);
        check_eq("fault_count", fault_count, 2);
        clear_fault();
    endtask

    task automatic test_backpressure();
        addr_t a;
        int w;
        rand_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            w = ($random(seed) & 1) ? 1 : 0;
            a = w_base[w] + ($random(seed) & 32'hFFF);
            send_req(a, i[0], $random(seed), 4'($random(seed)));
        end
        rand_ready = 1'b0;
        #1;
        dn_ready = 1'b1;
        drain_requests();
    endtask

    task automatic test_responses();
        rand_ready = 1'b1;
        for (int i = 0; i < 20; i++) begin
            send_rsp($random(seed), 1'($random(seed)));
        end
        rand_ready = 1'b0;
        #1;
        up_rsp_ready = 1'b1;
        drain_responses();
    endtask

    initial begin
        rst_n = 1'b1;
        up_valid = 1'b0;
        up_addr = '0;
        up_we = 1'b0;
        up_wdata = '0;
        up_strb = '0;
        dn_ready = 1'b1;
        dn_rsp_valid = 1'b0;
        dn_rsp_rdata = '0;
        dn_rsp_err = 1'b0;
        up_rsp_ready = 1'b1;
        cfg_we = 1'b0;
        cfg_idx = '0;
        cfg_base = '0;
        cfg_limit = '0;
        cfg_target = '0;
        cfg_en = 1'b0;
        fault_clr = 1'b0;
        for (int i = 0; i < 4; i++) begin
            w_en[i] = 1'b0;
            w_base[i] = '0;
            w_limit[i] = '0;
            w_target[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b0;
        @(negedge clk);
        test_reset_state();
        test_translation();
        test_latency();
        test_faults();
        test_backpressure();
        test_responses();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
